//--- sim.f
design/isa_pkg.sv
design/decode_pkg.sv
design/id_classify.sv
design/id_extract.sv
design/id_stage.sv
testbench/id_stage_checker.sv
testbench/tb_id_stage.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_stage -f sim.f

output="$(./obj_dir/Vtb_id_stage)" || true
echo "$output"

if grep -q "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1

//--- testbench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import isa_pkg::*;
    import decode_pkg::*;

    localparam int ADDR_W     = 16;
    localparam int CLK_PERIOD = 10;
    localparam int N_SWEEP    = 24;
    localparam int N_RAND     = 400;
    // Reset, sweep, random phase and drain
    localparam int N_TOTAL    = 2 + N_SWEEP + N_RAND + 5;

    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
        logic [OPC_W-1:0]   opc;
        logic               sgn_en;
        logic               imm_en;
        logic [IMM12_W-1:0] imm12;
        logic [IMM14_W-1:0] imm14;
        logic [IMM16_W-1:0] imm16;
        cc_t                cc;
        logic               has_src_gp;
        gp_idx_t            src_gp;
        gp_idx_t            tgt_gp;
        logic               tgt_gp_we;
        logic               has_src_sr;
        sr_idx_t            src_sr;
        sr_idx_t            tgt_sr;
        logic               tgt_sr_we;
    } dec_t;

    logic               iw_clk = 1'b0;
    logic               iw_rst;
    logic [ADDR_W-1:0]  pc;
    logic [INSTR_W-1:0] instr;
    logic               stall;
    logic               flush;
    logic [ADDR_W-1:0]  id_pc;
    logic [INSTR_W-1:0] id_instr;
    logic [OPC_W-1:0]   opc;
    logic               sgn_en;
    logic               imm_en;
    logic [IMM12_W-1:0] imm12;
    logic [IMM14_W-1:0] imm14;
    logic [IMM16_W-1:0] imm16;
    cc_t                cc;
    logic               has_src_gp;
    gp_idx_t            src_gp;
    gp_idx_t            tgt_gp;
    logic               tgt_gp_we;
    logic               has_src_sr;
    sr_idx_t            src_sr;
    sr_idx_t            tgt_sr;
    logic               tgt_sr_we;

    dec_t        act;
    dec_t        exp_s1 = '0;
    dec_t        exp_s2 = '0;
    logic [31:0] lfsr_state = 32'd66756;
    int          checks = 0;
    int          errors = 0;

    opc_e kept_ops [N_SWEEP] = '{
        NOP, MOVur, ADDur, SUBur, ANDur, CMPur, MOVui, ADDui,
        ANDui, CMPui, ADDsr, SUBsr, CMPsr, MOVsi, ADDsi, JCCur,
        JCCui, BCCso, BALso, MCCur, SRMOVur, SRADDsi, SRSUBsi, SRSTso
    };

    id_stage #(
        .ADDR_W (ADDR_W)
    ) uut (
        .*
    );

    assign act = {id_pc, id_instr, opc, sgn_en, imm_en, imm12, imm14, imm16, cc,
                  has_src_gp, src_gp, tgt_gp, tgt_gp_we, has_src_sr, src_sr, tgt_sr, tgt_sr_we};

    always #(CLK_PERIOD / 2) iw_clk = ~iw_clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic dec_t decode_ref(input logic [ADDR_W-1:0] p, input logic [INSTR_W-1:0] w);
        dec_t       d;
        logic [7:0] op;
        logic [3:0] cls;
        logic       is_cmp;
        logic       uses_flags;
        logic       has_tgt_gp;
        logic       has_tgt_sr;
        d = '0;
        op = w[23:16];
        cls = op[7:4];
        d.pc = p;
        d.instr = w;
        d.opc = op;
        if (op inside {MOVur, ADDur, SUBur, ANDur, CMPur, MOVui, ADDui, ANDui, CMPui,
                       ADDsr, SUBsr, CMPsr, MOVsi, ADDsi, JCCur, JCCui, BCCso, BALso,
                       MCCur, SRMOVur, SRADDsi, SRSUBsi, SRSTso}) begin
            is_cmp = op inside {CMPur, CMPui, CMPsr};
            uses_flags = op inside {JCCur, JCCui, BCCso, BALso, MCCur};
            d.sgn_en = cls == 4'h2 || cls == 4'h3 ||
                       op inside {BCCso, BALso, SRADDsi, SRSUBsi, SRSTso};
            d.imm_en = cls == 4'h1 || cls == 4'h3 ||
                       op inside {JCCui, BCCso, BALso, SRADDsi, SRSUBsi, SRSTso};
            if (cls == 4'h1 || cls == 4'h3 || op inside {JCCui, BCCso, SRSTso}) begin
                d.imm12 = w[11:0];
            end else if (op inside {SRADDsi, SRSUBsi}) begin
                d.imm14 = w[13:0];
            end else if (op == BALso) begin
                d.imm16 = w[15:0];
            end
            if (op == JCCur) begin
                d.cc = w[13:10];
            end else if (op inside {JCCui, BCCso}) begin
                d.cc = w[15:12];
            end else if (op == MCCur) begin
                d.cc = w[7:4];
            end
            d.tgt_gp_we = (cls <= 4'h3 && !is_cmp) || op == MCCur;
            has_tgt_gp = d.tgt_gp_we || is_cmp;
            d.has_src_gp = cls == 4'h0 || cls == 4'h2 || op == MCCur;
            d.tgt_sr_we = op inside {SRMOVur, SRADDsi, SRSUBsi};
            has_tgt_sr = d.tgt_sr_we || op == SRSTso;
            d.has_src_sr = op inside {SRMOVur, SRSTso} || uses_flags;
            if (has_tgt_gp) d.tgt_gp = w[15:12];
            if (d.has_src_gp) d.src_gp = w[11:8];
            if (has_tgt_sr) d.tgt_sr = w[15:14];
            if (uses_flags) begin
                d.src_sr = SR_IDX_FL;
            end else if (d.has_src_sr) begin
                d.src_sr = w[13:12];
            end
        end
        return d;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    // Expected two-deep pipeline
    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            exp_s1 <= '0;
            exp_s2 <= '0;
        end else if (flush) begin
            exp_s1 <= '0;
            exp_s2 <= '0;
        end else if (!stall) begin
            exp_s2 <= exp_s1;
            exp_s1 <= decode_ref(pc, instr);
        end
    end

    always @(negedge iw_clk) begin
        if (!iw_rst) begin
            check_value("pc", 32'(act.pc), 32'(exp_s2.pc));
            check_value("instr", 32'(act.instr), 32'(exp_s2.instr));
            check_value("opc", 32'(act.opc), 32'(exp_s2.opc));
            check_value("sgn_en", 32'(act.sgn_en), 32'(exp_s2.sgn_en));
            check_value("imm_en", 32'(act.imm_en), 32'(exp_s2.imm_en));
            check_value("imm12", 32'(act.imm12), 32'(exp_s2.imm12));
            check_value("imm14", 32'(act.imm14), 32'(exp_s2.imm14));
            check_value("imm16", 32'(act.imm16), 32'(exp_s2.imm16));
            check_value("cc", 32'(act.cc), 32'(exp_s2.cc));
            check_value("has_src_gp", 32'(act.has_src_gp), 32'(exp_s2.has_src_gp));
            check_value("src_gp", 32'(act.src_gp), 32'(exp_s2.src_gp));
            check_value("tgt_gp", 32'(act.tgt_gp), 32'(exp_s2.tgt_gp));
            check_value("tgt_gp_we", 32'(act.tgt_gp_we), 32'(exp_s2.tgt_gp_we));
            check_value("has_src_sr", 32'(act.has_src_sr), 32'(exp_s2.has_src_sr));
            check_value("src_sr", 32'(act.src_sr), 32'(exp_s2.src_sr));
            check_value("tgt_sr", 32'(act.tgt_sr), 32'(exp_s2.tgt_sr));
            check_value("tgt_sr_we", 32'(act.tgt_sr_we), 32'(exp_s2.tgt_sr_we));
        end
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  op;
        iw_rst = 1'b1;
        pc = '0;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (2) @(posedge iw_clk);
        iw_rst <= 1'b0;
        // Every kept opcode back to back
        for (int i = 0; i < N_SWEEP; i++) begin
            @(posedge iw_clk);
            take_bits(16, r);
            instr <= {kept_ops[i], r[15:0]};
            take_bits(ADDR_W, r);
            pc <= r[ADDR_W-1:0];
        end
        for (int i = 0; i < N_RAND; i++) begin
            @(posedge iw_clk);
            take_bits(5, r);
            if (r[4:0] < 5'd24) begin
                op = kept_ops[r[4:0]];
            end else begin
                take_bits(8, r);
                op = r[7:0];
            end
            take_bits(16, r);
            instr <= {op, r[15:0]};
            take_bits(ADDR_W, r);
            pc <= r[ADDR_W-1:0];
            take_bits(3, r);
            stall <= (r[2:0] == 3'd0);
            take_bits(4, r);
            flush <= (r[3:0] == 4'd0);
        end
        @(posedge iw_clk);
        stall <= 1'b0;
        flush <= 1'b0;
        repeat (3) @(posedge iw_clk);
        @(negedge iw_clk);
        #1;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.u_checker.assert_fails);
        if (errors == 0 && uut.u_checker.assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((N_TOTAL + 20) * CLK_PERIOD);
        $display("Timeout: the test did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- testbench/id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker #(
    parameter int ADDR_W = 16
) (
    input logic                           iw_clk,
    input logic                           iw_rst,
    input logic                           stall,
    input logic                           flush,
    input logic [ADDR_W-1:0]              id_pc,
    input logic [isa_pkg::INSTR_W-1:0]    id_instr,
    input logic [isa_pkg::OPC_W-1:0]      opc,
    input logic                           sgn_en,
    input logic                           imm_en,
    input logic [decode_pkg::IMM12_W-1:0] imm12,
    input logic [decode_pkg::IMM14_W-1:0] imm14,
    input logic [decode_pkg::IMM16_W-1:0] imm16,
    input decode_pkg::cc_t                cc,
    input logic                           has_src_gp,
    input decode_pkg::gp_idx_t            src_gp,
    input decode_pkg::gp_idx_t            tgt_gp,
    input logic                           tgt_gp_we,
    input logic                           has_src_sr,
    input decode_pkg::sr_idx_t            src_sr,
    input decode_pkg::sr_idx_t            tgt_sr,
    input logic                           tgt_sr_we
);
    // Pc plus 96 bits of decoded word
    logic [ADDR_W+95:0] outs;
    int                 assert_fails = 0;

    assign outs = {id_pc, id_instr, opc, sgn_en, imm_en, imm12, imm14, imm16, cc,
                   has_src_gp, src_gp, tgt_gp, tgt_gp_we, has_src_sr, src_sr, tgt_sr, tgt_sr_we};

    reset_clears: assert property (@(posedge iw_clk) iw_rst |=> outs == '0)
        else begin
            $error("outputs not zero after reset");
            assert_fails++;
        end

    flush_clears: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> outs == '0)
        else begin
            $error("outputs not zero one cycle after flush");
            assert_fails++;
        end

    stall_holds: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> $stable(outs))
        else begin
            $error("outputs changed across a stall");
            assert_fails++;
        end

    // Only BALso selects imm16
    imm16_flags: assert property (@(posedge iw_clk) disable iff (iw_rst)
        imm16 != '0 |-> (sgn_en && imm_en))
        else begin
            $error("nonzero imm16 without sgn_en and imm_en");
            assert_fails++;
        end

endmodule

bind id_stage id_stage_checker #(.ADDR_W(ADDR_W)) u_checker (.*);

//--- design/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
    parameter int ADDR_W = 16
) (
    input  logic                           iw_clk,
    input  logic                           iw_rst,
    input  logic [ADDR_W-1:0]              pc,
    input  logic [isa_pkg::INSTR_W-1:0]    instr,
    input  logic                           stall,
    input  logic                           flush,
    output logic [ADDR_W-1:0]              id_pc,
    output logic [isa_pkg::INSTR_W-1:0]    id_instr,
    output logic [isa_pkg::OPC_W-1:0]      opc,
    output logic                           sgn_en,
    output logic                           imm_en,
    output logic [decode_pkg::IMM12_W-1:0] imm12,
    output logic [decode_pkg::IMM14_W-1:0] imm14,
    output logic [decode_pkg::IMM16_W-1:0] imm16,
    output decode_pkg::cc_t                cc,
    output logic                           has_src_gp,
    output decode_pkg::gp_idx_t            src_gp,
    output decode_pkg::gp_idx_t            tgt_gp,
    output logic                           tgt_gp_we,
    output logic                           has_src_sr,
    output decode_pkg::sr_idx_t            src_sr,
    output decode_pkg::sr_idx_t            tgt_sr,
    output logic                           tgt_sr_we
);
    import isa_pkg::*;
    import decode_pkg::*;

    // Stage 1 to stage 2
    logic [ADDR_W-1:0]  s1_pc;
    logic [INSTR_W-1:0] s1_instr;
    logic [OPC_W-1:0]   s1_opc;
    logic               s1_sgn_en;
    logic               s1_imm_en;
    logic               s1_tgt_gp_we;
    logic               s1_has_tgt_gp;
    logic               s1_has_src_gp;
    logic               s1_uses_flags;
    logic               s1_has_src_sr;
    logic               s1_tgt_sr_we;
    logic               s1_has_tgt_sr;
    imm_sel_e           s1_imm_sel;
    cc_sel_e            s1_cc_sel;

    id_classify #(
        .ADDR_W (ADDR_W)
    ) u_classify (
        .*
    );

    // Stage 2 registers are the decode outputs
    id_extract #(
        .ADDR_W (ADDR_W)
    ) u_extract (
        .pc    (id_pc),
        .instr (id_instr),
        .*
    );

endmodule

//--- design/id_extract.sv
`timescale 1ns/1ps

module id_extract #(
    parameter int ADDR_W = 16
) (
    input  logic                           iw_clk,
    input  logic                           iw_rst,
    input  logic                           stall,
    input  logic                           flush,
    input  logic [ADDR_W-1:0]              s1_pc,
    input  logic [isa_pkg::INSTR_W-1:0]    s1_instr,
    input  logic [isa_pkg::OPC_W-1:0]      s1_opc,
    input  logic                           s1_sgn_en,
    input  logic                           s1_imm_en,
    input  logic                           s1_tgt_gp_we,
    input  logic                           s1_has_tgt_gp,
    input  logic                           s1_has_src_gp,
    input  logic                           s1_uses_flags,
    input  logic                           s1_has_src_sr,
    input  logic                           s1_tgt_sr_we,
    input  logic                           s1_has_tgt_sr,
    input  decode_pkg::imm_sel_e           s1_imm_sel,
    input  decode_pkg::cc_sel_e            s1_cc_sel,
    output logic [ADDR_W-1:0]              pc,
    output logic [isa_pkg::INSTR_W-1:0]    instr,
    output logic [isa_pkg::OPC_W-1:0]      opc,
    output logic                           sgn_en,
    output logic                           imm_en,
    output logic [decode_pkg::IMM12_W-1:0] imm12,
    output logic [decode_pkg::IMM14_W-1:0] imm14,
    output logic [decode_pkg::IMM16_W-1:0] imm16,
    output decode_pkg::cc_t                cc,
    output logic                           has_src_gp,
    output decode_pkg::gp_idx_t            src_gp,
    output decode_pkg::gp_idx_t            tgt_gp,
    output logic                           tgt_gp_we,
    output logic                           has_src_sr,
    output decode_pkg::sr_idx_t            src_sr,
    output decode_pkg::sr_idx_t            tgt_sr,
    output logic                           tgt_sr_we
);
    import isa_pkg::*;
    import decode_pkg::*;

    logic [IMM12_W-1:0] imm12_d;
    logic [IMM14_W-1:0] imm14_d;
    logic [IMM16_W-1:0] imm16_d;
    cc_t                cc_d;
    gp_idx_t            src_gp_d;
    gp_idx_t            tgt_gp_d;
    sr_idx_t            src_sr_d;
    sr_idx_t            tgt_sr_d;

    // Only the selected immediate is nonzero
    always_comb begin
        imm12_d = '0;
        imm14_d = '0;
        imm16_d = '0;
        case (s1_imm_sel)
            IMM_I12: imm12_d = s1_instr[IMM12_W-1:0];
            IMM_I14: imm14_d = s1_instr[IMM14_W-1:0];
            IMM_I16: imm16_d = s1_instr[IMM16_W-1:0];
            default: begin
            end
        endcase
    end

    always_comb begin
        case (s1_cc_sel)
            CC_HI:   cc_d = s1_instr[15:12];
            CC_MID:  cc_d = s1_instr[13:10];
            CC_LO:   cc_d = s1_instr[7:4];
            default: cc_d = '0;
        endcase
    end

    assign tgt_gp_d = s1_has_tgt_gp ? s1_instr[15:12] : '0;
    assign src_gp_d = s1_has_src_gp ? s1_instr[11:8] : '0;
    assign tgt_sr_d = s1_has_tgt_sr ? s1_instr[15:14] : '0;
    // Flag consumers override the encoded SR source
    assign src_sr_d = s1_uses_flags ? SR_IDX_FL :
                      s1_has_src_sr ? s1_instr[13:12] : '0;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            {pc, instr, opc, sgn_en, imm_en} <= '0;
            {imm12, imm14, imm16, cc} <= '0;
            {has_src_gp, src_gp, tgt_gp, tgt_gp_we} <= '0;
            {has_src_sr, src_sr, tgt_sr, tgt_sr_we} <= '0;
        end else if (flush) begin
            {pc, instr, opc, sgn_en, imm_en} <= '0;
            {imm12, imm14, imm16, cc} <= '0;
            {has_src_gp, src_gp, tgt_gp, tgt_gp_we} <= '0;
            {has_src_sr, src_sr, tgt_sr, tgt_sr_we} <= '0;
        end else if (!stall) begin
            pc         <= s1_pc;
            instr      <= s1_instr;
            opc        <= s1_opc;
            sgn_en     <= s1_sgn_en;
            imm_en     <= s1_imm_en;
            imm12      <= imm12_d;
            imm14      <= imm14_d;
            imm16      <= imm16_d;
            cc         <= cc_d;
            has_src_gp <= s1_has_src_gp;
            src_gp     <= src_gp_d;
            tgt_gp     <= tgt_gp_d;
            tgt_gp_we  <= s1_tgt_gp_we;
            has_src_sr <= s1_has_src_sr;
            src_sr     <= src_sr_d;
            tgt_sr     <= tgt_sr_d;
            tgt_sr_we  <= s1_tgt_sr_we;
        end
    end

endmodule

//--- design/id_classify.sv
`timescale 1ns/1ps

module id_classify #(
    parameter int ADDR_W = 16
) (
    input  logic                        iw_clk,
    input  logic                        iw_rst,
    input  logic                        stall,
    input  logic                        flush,
    input  logic [ADDR_W-1:0]           pc,
    input  logic [isa_pkg::INSTR_W-1:0] instr,
    output logic [ADDR_W-1:0]           s1_pc,
    output logic [isa_pkg::INSTR_W-1:0] s1_instr,
    output logic [isa_pkg::OPC_W-1:0]   s1_opc,
    output logic                        s1_sgn_en,
    output logic                        s1_imm_en,
    output logic                        s1_tgt_gp_we,
    output logic                        s1_has_tgt_gp,
    output logic                        s1_has_src_gp,
    output logic                        s1_uses_flags,
    output logic                        s1_has_src_sr,
    output logic                        s1_tgt_sr_we,
    output logic                        s1_has_tgt_sr,
    output decode_pkg::imm_sel_e        s1_imm_sel,
    output decode_pkg::cc_sel_e         s1_cc_sel
);
    import isa_pkg::*;
    import decode_pkg::*;

    opc_e     opc;
    logic     sgn_en;
    logic     imm_en;
    logic     tgt_gp_we;
    logic     is_cmp;
    logic     has_src_gp;
    logic     uses_flags;
    logic     sr_src_op;
    logic     tgt_sr_we;
    logic     has_tgt_gp;
    logic     has_src_sr;
    logic     has_tgt_sr;
    imm_sel_e imm_sel;
    cc_sel_e  cc_sel;

    assign opc = opc_e'(instr[INSTR_W-1:OPC_LSB]);

    always_comb begin
        sgn_en     = 1'b0;
        imm_en     = 1'b0;
        tgt_gp_we  = 1'b0;
        is_cmp     = 1'b0;
        has_src_gp = 1'b0;
        uses_flags = 1'b0;
        sr_src_op  = 1'b0;
        tgt_sr_we  = 1'b0;
        case (opc)
            MOVur, ADDur, SUBur, ANDur: begin
                tgt_gp_we  = 1'b1;
                has_src_gp = 1'b1;
            end
            CMPur: begin
                is_cmp     = 1'b1;
                has_src_gp = 1'b1;
            end
            MOVui, ADDui, ANDui: begin
                imm_en    = 1'b1;
                tgt_gp_we = 1'b1;
            end
            CMPui: begin
                imm_en = 1'b1;
                is_cmp = 1'b1;
            end
            ADDsr, SUBsr: begin
                sgn_en     = 1'b1;
                tgt_gp_we  = 1'b1;
                has_src_gp = 1'b1;
            end
            CMPsr: begin
                sgn_en     = 1'b1;
                is_cmp     = 1'b1;
                has_src_gp = 1'b1;
            end
            MOVsi, ADDsi: begin
                sgn_en    = 1'b1;
                imm_en    = 1'b1;
                tgt_gp_we = 1'b1;
            end
            JCCur: begin
                uses_flags = 1'b1;
            end
            JCCui: begin
                imm_en     = 1'b1;
                uses_flags = 1'b1;
            end
            BCCso, BALso: begin
                sgn_en     = 1'b1;
                imm_en     = 1'b1;
                uses_flags = 1'b1;
            end
            MCCur: begin
                tgt_gp_we  = 1'b1;
                has_src_gp = 1'b1;
                uses_flags = 1'b1;
            end
            SRMOVur: begin
                sr_src_op = 1'b1;
                tgt_sr_we = 1'b1;
            end
            SRADDsi, SRSUBsi: begin
                sgn_en    = 1'b1;
                imm_en    = 1'b1;
                tgt_sr_we = 1'b1;
            end
            SRSTso: begin
                sgn_en    = 1'b1;
                imm_en    = 1'b1;
                sr_src_op = 1'b1;
            end
            default: begin
                // NOP and unlisted opcodes keep the zero decode
            end
        endcase
    end

    assign has_tgt_gp = tgt_gp_we | is_cmp;
    assign has_tgt_sr = tgt_sr_we | (opc == SRSTso);
    // Flag consumers read SR implicitly
    assign has_src_sr = sr_src_op | uses_flags;

    always_comb begin
        imm_sel = IMM_NONE;
        cc_sel  = CC_NONE;
        case (opc)
            MOVui, ADDui, ANDui, CMPui, MOVsi, ADDsi, SRSTso: imm_sel = IMM_I12;
            SRADDsi, SRSUBsi: imm_sel = IMM_I14;
            BALso:            imm_sel = IMM_I16;
            JCCur:            cc_sel  = CC_MID;
            JCCui, BCCso: begin
                imm_sel = IMM_I12;
                cc_sel  = CC_HI;
            end
            MCCur:            cc_sel  = CC_LO;
            default: begin
            end
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            {s1_pc, s1_instr, s1_opc} <= '0;
            {s1_sgn_en, s1_imm_en, s1_tgt_gp_we, s1_has_tgt_gp, s1_has_src_gp} <= '0;
            {s1_uses_flags, s1_has_src_sr, s1_tgt_sr_we, s1_has_tgt_sr} <= '0;
            s1_imm_sel <= IMM_NONE;
            s1_cc_sel  <= CC_NONE;
        end else if (flush) begin
            {s1_pc, s1_instr, s1_opc} <= '0;
            {s1_sgn_en, s1_imm_en, s1_tgt_gp_we, s1_has_tgt_gp, s1_has_src_gp} <= '0;
            {s1_uses_flags, s1_has_src_sr, s1_tgt_sr_we, s1_has_tgt_sr} <= '0;
            s1_imm_sel <= IMM_NONE;
            s1_cc_sel  <= CC_NONE;
        end else if (!stall) begin
            s1_pc         <= pc;
            s1_instr      <= instr;
            s1_opc        <= instr[INSTR_W-1:OPC_LSB];
            s1_sgn_en     <= sgn_en;
            s1_imm_en     <= imm_en;
            s1_tgt_gp_we  <= tgt_gp_we;
            s1_has_tgt_gp <= has_tgt_gp;
            s1_has_src_gp <= has_src_gp;
            s1_uses_flags <= uses_flags;
            s1_has_src_sr <= has_src_sr;
            s1_tgt_sr_we  <= tgt_sr_we;
            s1_has_tgt_sr <= has_tgt_sr;
            s1_imm_sel    <= imm_sel;
            s1_cc_sel     <= cc_sel;
        end
    end

endmodule

//--- design/decode_pkg.sv
package decode_pkg;

    typedef logic [3:0] gp_idx_t;
    typedef logic [1:0] sr_idx_t;
    typedef logic [3:0] cc_t;

    localparam int IMM12_W = 12;
    localparam int IMM14_W = 14;
    localparam int IMM16_W = 16;

    // Immediate field used by the op
    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_I12,
        IMM_I14,
        IMM_I16
    } imm_sel_e;

    // Position of the condition code
    typedef enum logic [1:0] {
        CC_NONE,
        CC_HI,
        CC_MID,
        CC_LO
    } cc_sel_e;

endpackage

//--- design/isa_pkg.sv
package isa_pkg;

    localparam int INSTR_W = 24;
    localparam int OPC_W   = 8;
    // Opcode occupies the top byte of the word
    localparam int OPC_LSB = INSTR_W - OPC_W;

    // Upper nibble is the op class
    typedef enum logic [OPC_W-1:0] {
        NOP     = 8'h00,
        // GP register ALU
        MOVur   = 8'h01,
        ADDur   = 8'h02,
        SUBur   = 8'h03,
        ANDur   = 8'h04,
        CMPur   = 8'h05,
        // GP unsigned immediate
        MOVui   = 8'h10,
        ADDui   = 8'h11,
        ANDui   = 8'h12,
        CMPui   = 8'h13,
        // GP signed register
        ADDsr   = 8'h20,
        SUBsr   = 8'h21,
        CMPsr   = 8'h22,
        // GP signed immediate
        MOVsi   = 8'h30,
        ADDsi   = 8'h31,
        // Branches and conditional move
        JCCur   = 8'h70,
        JCCui   = 8'h71,
        BCCso   = 8'h72,
        BALso   = 8'h73,
        MCCur   = 8'h74,
        // Special registers
        SRMOVur = 8'hF0,
        SRADDsi = 8'hF1,
        SRSUBsi = 8'hF2,
        SRSTso  = 8'hF3
    } opc_e;

    // Implicit SR source of every flag consumer
    localparam logic [1:0] SR_IDX_FL = 2'd2;

endpackage
